// File: design/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int data_width = 8;  // Data byte
    localparam int addr_width = 16; // Bus address

    typedef logic [data_width-1:0] byte_t;
    typedef logic [addr_width-1:0] addr_t;

    localparam addr_t reset_pc     = 16'h0200; // First opcode fetch after reset
    localparam byte_t zero_page    = 8'h00;    // High address byte in zero-page cycles
    localparam byte_t reset_opcode = 8'hea;    // NOP sits in the opcode register at reset

    // Opcode field positions
    localparam int alu_op_lsb     = 5; // aaa field, opcode[7:5]
    localparam int flag_value_bit = 5; // New C value for CLC/SEC
    localparam int reg_sel_lsb    = 0; // Store register, opcode[1:0]

    // ALU operations, aaa field of the group-one opcodes
    localparam logic [2:0] op_ora = 3'd0;
    localparam logic [2:0] op_and = 3'd1;
    localparam logic [2:0] op_eor = 3'd2;
    localparam logic [2:0] op_adc = 3'd3;
    localparam logic [2:0] op_lda = 3'd5; // Operand passes through
    localparam logic [2:0] op_cmp = 3'd6; // Subtract with carry forced
    localparam logic [2:0] op_sbc = 3'd7;

    // Counter operations share the alu_op field
    localparam logic [2:0] cnt_pass = 3'd0; // TXA/TYA
    localparam logic [2:0] cnt_inc  = 3'd1; // INX/INY
    localparam logic [2:0] cnt_dec  = 3'd2; // DEX/DEY

    // One-hot cycle state
    typedef struct packed {
        logic byte1;     // Opcode fetch
        logic byte2;     // Operand or dummy fetch
        logic zeropage1; // Zero-page read or write
    } cycle_t;

    typedef struct packed {
        byte_t      opcode;    // Latched opcode
        logic       imm_alu;   // ORA/AND/EOR/ADC/CMP/SBC/CPX/CPY #
        logic       imm_load;  // LDA/LDX/LDY #
        logic       zp_read;   // Loads and ALU ops on $00
        logic       zp_store;  // STA/STX/STY $00
        logic       transfer;  // TAX/TAY/TXA/TYA
        logic       count;     // INX/INY/DEX/DEY
        logic       flag_op;   // CLC/SEC/CLV
        logic       update_a;
        logic       update_x;
        logic       update_y;
        logic       update_nz;
        logic       cmp;       // CMP/CPX/CPY
        logic       adc_sbc;
        logic       uses_x;    // X is the ALU or counter source
        logic       uses_y;    // Y is the ALU or counter source
        logic [2:0] alu_op;    // ALU or counter operation
    } decoded_t;

    // Internal data bus sources, ORed together
    typedef struct packed {
        logic data_in;
        logic alu;
        logic a;
        logic count;
    } db_sel_t;

    typedef struct packed {
        db_sel_t db;
        logic    n_db7;        // N from DB bit 7
        logic    z_dbz;        // Z from DB == 0
        logic    v_alu;
        logic    c_alu;
        logic    c_ir5;        // C from opcode bit 5
        logic    v_ir5;        // V cleared by CLV
        logic    a;            // Load A from DB
        logic    x;
        logic    y;
        logic    pc_increment;
    } ctrl_t;

    typedef struct packed {
        addr_t address;
        byte_t data_out;
        logic  write_enable;
    } bus_req_t;

    typedef struct packed {
        byte_t opcode;
        addr_t pc;
        byte_t a;
        byte_t x;
        byte_t y;
        byte_t p; // NV11_00ZC
    } debug_t;

endpackage : cpu_pkg

`default_nettype wire

// File: design/instr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decode
    ( input  logic              clock,
      input  logic              reset,
      input  logic              enable,
      input  cpu_pkg::byte_t    data_in,
      input  logic              fetch,   // byte1 cycle
      output cpu_pkg::decoded_t decoded,
      output cpu_pkg::byte_t    opcode
      );

    always_ff @(posedge clock)
    begin
        if (reset)
            opcode <= cpu_pkg::reset_opcode;
        else if (enable && fetch)
            opcode <= data_in; // Held until the next byte1 ends
    end

    // Addressing and group patterns
    wire logic imm_a  = opcode ==? 8'b???_010_01; // #$00, group one
    wire logic imm_xy = opcode ==? 8'b1??_000_?0; // LDX/LDY/CPX/CPY #$00
    wire logic zp     = opcode ==? 8'b???_001_??; // $00
    wire logic ld     = opcode ==? 8'b101_???_??;
    wire logic st     = opcode ==? 8'b100_???_??;
    wire logic arith  = (opcode ==? 8'b???_???_01) & ~ld & ~st;
    wire logic cmp_a  = opcode ==? 8'b110_???_01;
    wire logic cpxy   = opcode ==? 8'b11?_000_00;

    // Implied opcodes
    wire logic tax = opcode == 8'haa;
    wire logic tay = opcode == 8'ha8;
    wire logic txa = opcode == 8'h8a;
    wire logic tya = opcode == 8'h98;
    wire logic inx = opcode == 8'he8;
    wire logic iny = opcode == 8'hc8;
    wire logic dex = opcode == 8'hca;
    wire logic dey = opcode == 8'h88;

    wire logic ld_any = (imm_a | imm_xy | zp) & ld;
    wire logic arith_any = (imm_a | zp) & arith;

    always_comb
    begin
        decoded = '0;
        decoded.opcode    = opcode;
        decoded.imm_alu   = (imm_a & arith) | cpxy;
        decoded.imm_load  = (imm_a | imm_xy) & ld;
        decoded.zp_read   = zp & (ld | arith);
        decoded.zp_store  = zp & st;
        decoded.transfer  = tax | tay | txa | tya;
        decoded.count     = inx | iny | dex | dey;
        decoded.flag_op   = (opcode ==? 8'b00?_110_00) | (opcode == 8'hb8); // CLC/SEC, CLV
        decoded.update_a  = (arith_any & ~cmp_a) | (ld_any & opcode[0]) | txa | tya;
        decoded.update_x  = (ld_any & opcode[1]) | tax | inx | dex;
        decoded.update_y  = (ld_any & (opcode[1:0] == 2'b00)) | tay | iny | dey;
        decoded.cmp       = (arith_any & cmp_a) | cpxy;
        decoded.update_nz = decoded.update_a | decoded.update_x | decoded.update_y
                          | decoded.cmp;
        decoded.adc_sbc   = arith_any & (opcode ==? 8'b?11_???_01);
        decoded.uses_x    = (cpxy & opcode[5]) | txa | inx | dex; // CPX is E0
        decoded.uses_y    = (cpxy & ~opcode[5]) | tya | iny | dey;

        // CPX opcode field reads as SBC, forced to compare
        decoded.alu_op = cpxy             ? cpu_pkg::op_cmp :
                         (inx | iny)      ? cpu_pkg::cnt_inc :
                         (dex | dey)      ? cpu_pkg::cnt_dec :
                         decoded.transfer ? cpu_pkg::cnt_pass :
                         opcode[cpu_pkg::alu_op_lsb +: 3];
    end

    // Immediate, implied and zero page never overlap
    a_one_mode: assert property (@(posedge clock) disable iff (reset)
        $onehot0({decoded.imm_alu | decoded.imm_load,
                  decoded.transfer | decoded.count | decoded.flag_op,
                  decoded.zp_read | decoded.zp_store}));

endmodule : instr_decode

`default_nettype wire

// File: design/cycle_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module cycle_sequencer
    ( input  logic               clock,
      input  logic               reset,
      input  logic               enable,
      input  cpu_pkg::decoded_t  decoded,
      input  cpu_pkg::byte_t     data_in,    // Raw bus read data
      input  cpu_pkg::addr_t     pc,
      input  cpu_pkg::byte_t     store_data,
      output cpu_pkg::bus_req_t  bus,
      output cpu_pkg::byte_t     data_reg,   // Registered read data
      output cpu_pkg::ctrl_t     ctrl,
      output cpu_pkg::cycle_t    cycle
      );

    cpu_pkg::cycle_t next_cycle;

    wire logic zp_class = decoded.zp_read | decoded.zp_store;
    wire logic implied  = ~(decoded.imm_alu | decoded.imm_load | zp_class); // 1-byte opcodes

    // Loads go straight from the data register to DB
    wire logic load = (decoded.imm_load | decoded.zp_read)
                    & (decoded.alu_op == cpu_pkg::op_lda);

    always_comb
    begin
        next_cycle = '0;
        next_cycle.byte2     = cycle.byte1;
        next_cycle.zeropage1 = cycle.byte2 & zp_class;
        next_cycle.byte1     = (cycle.byte2 & ~zp_class) | cycle.zeropage1;
    end

    always_comb
    begin
        bus.write_enable = cycle.zeropage1 & decoded.zp_store;
        bus.address = cycle.zeropage1 ? {cpu_pkg::zero_page, data_reg} : pc; // ADL from operand
        bus.data_out = bus.write_enable ? store_data : '0;
    end

    // Control word
    always_comb
    begin
        ctrl = '0;
        ctrl.pc_increment = cycle.byte1 | (cycle.byte2 & ~implied);

        // Results of the finishing instruction land in byte1
        if (cycle.byte1)
        begin
            ctrl.db.data_in = load;
            ctrl.db.alu     = (decoded.imm_alu | decoded.zp_read) & ~load;
            ctrl.db.a       = decoded.transfer & ~decoded.update_a; // TAX/TAY
            ctrl.db.count   = decoded.count | (decoded.transfer & decoded.update_a);

            ctrl.n_db7 = decoded.update_nz;
            ctrl.z_dbz = decoded.update_nz;
            ctrl.v_alu = decoded.adc_sbc;
            ctrl.c_alu = decoded.adc_sbc | decoded.cmp;
            ctrl.c_ir5 = decoded.flag_op & ~decoded.alu_op[2]; // CLC/SEC
            ctrl.v_ir5 = decoded.flag_op & decoded.alu_op[2];  // CLV is B8

            ctrl.a = decoded.update_a;
            ctrl.x = decoded.update_x;
            ctrl.y = decoded.update_y;
        end
    end

    always_ff @(posedge clock)
    begin
        if (reset)
            cycle <= '{byte1: 1'b1, default: 1'b0};
        else if (enable)
            cycle <= next_cycle;
    end

    // After a write the register reflects the byte just written
    always_ff @(posedge clock)
    begin
        if (enable)
            data_reg <= bus.write_enable ? bus.data_out : data_in;
    end

    a_cycle_onehot: assert property (@(posedge clock) disable iff (reset)
        $onehot(cycle));

    // A store frozen in zeropage1 keeps its address and data
    a_write_hold: assert property (@(posedge clock) disable iff (reset)
        bus.write_enable && !enable |=> bus.write_enable && $stable(bus));

endmodule : cycle_sequencer

`default_nettype wire

// File: design/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit
    ( input  cpu_pkg::byte_t    a,
      input  cpu_pkg::byte_t    x,
      input  cpu_pkg::byte_t    y,
      input  cpu_pkg::byte_t    operand,
      input  logic              carry_in,
      input  cpu_pkg::decoded_t decoded,
      output cpu_pkg::byte_t    result,
      output logic              carry_out,
      output logic              overflow_out,
      output cpu_pkg::byte_t    count
      );

    cpu_pkg::byte_t first;   // A, or X/Y for CPX/CPY
    cpu_pkg::byte_t addend;
    cpu_pkg::byte_t count_in;

    wire logic [2:0] op = decoded.alu_op;
    wire logic sub      = op[2];                // CMP and SBC subtract
    wire logic carry    = carry_in | ~op[0];    // CMP always uses C=1

    assign first  = decoded.uses_x ? x : decoded.uses_y ? y : a;
    assign addend = sub ? ~operand : operand;

    wire logic [8:0] sum = {1'b0, first} + {1'b0, addend} + 9'(carry); // Binary only

    always_comb
    begin
        case (op)
            cpu_pkg::op_ora: result = first | operand;
            cpu_pkg::op_and: result = first & operand;
            cpu_pkg::op_eor: result = first ^ operand;
            cpu_pkg::op_lda: result = operand;
            cpu_pkg::op_adc,
            cpu_pkg::op_cmp,
            cpu_pkg::op_sbc: result = sum[7:0];
            default:         result = '0; // STA slot
        endcase
    end

    assign carry_out    = sum[8];
    assign overflow_out = (first[7] ^ result[7]) & (addend[7] ^ result[7]); // Sign flip

    // Counter for transfers and INX/INY/DEX/DEY
    wire logic index_src = decoded.count | decoded.transfer;
    wire logic inc = decoded.count & (decoded.alu_op == cpu_pkg::cnt_inc);
    wire logic dec = decoded.count & (decoded.alu_op == cpu_pkg::cnt_dec);

    assign count_in = index_src ? (decoded.uses_y ? y : x) : operand;
    assign count    = count_in + {cpu_pkg::data_width{dec}} + cpu_pkg::byte_t'(inc); // Wraps

endmodule : alu_unit

`default_nettype wire

// File: design/register_result.sv
`timescale 1ns/1ps
`default_nettype none

module register_result
    ( input  logic              clock,
      input  logic              reset,
      input  logic              enable,
      input  cpu_pkg::ctrl_t    ctrl,
      input  cpu_pkg::decoded_t decoded,
      input  cpu_pkg::byte_t    data_in,      // Registered read data
      input  cpu_pkg::byte_t    alu_result,
      input  logic              alu_carry,
      input  logic              alu_overflow,
      input  cpu_pkg::byte_t    count,
      output cpu_pkg::byte_t    a,
      output cpu_pkg::byte_t    x,
      output cpu_pkg::byte_t    y,
      output logic              carry,
      output cpu_pkg::byte_t    store_data,
      output cpu_pkg::addr_t    pc,
      output cpu_pkg::debug_t   debug
      );

    cpu_pkg::byte_t db; // Internal data bus
    logic flag_n;
    logic flag_v;
    logic flag_z;
    logic flag_c;

    assign db = (ctrl.db.data_in ? data_in    : '0)
              | (ctrl.db.alu     ? alu_result : '0)
              | (ctrl.db.a       ? a          : '0)
              | (ctrl.db.count   ? count      : '0);

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            a      <= '0;
            x      <= '0;
            y      <= '0;
            flag_n <= 1'b0;
            flag_v <= 1'b0;
            flag_z <= 1'b0;
            flag_c <= 1'b0;
            pc     <= cpu_pkg::reset_pc;
        end
        else if (enable)
        begin
            if (ctrl.a)
                a <= db;
            if (ctrl.x)
                x <= db;
            if (ctrl.y)
                y <= db;
            if (ctrl.n_db7)
                flag_n <= db[7];
            if (ctrl.z_dbz)
                flag_z <= (db == '0);
            if (ctrl.v_ir5)
                flag_v <= 1'b0; // CLV only ever clears V
            else if (ctrl.v_alu)
                flag_v <= alu_overflow;
            if (ctrl.c_ir5)
                flag_c <= decoded.opcode[cpu_pkg::flag_value_bit]; // SEC sets, CLC clears
            else if (ctrl.c_alu)
                flag_c <= alu_carry;
            pc <= pc + cpu_pkg::addr_t'(ctrl.pc_increment);
        end
    end

    assign carry = flag_c;

    // STY 84, STA 85, STX 86
    always_comb
    begin
        case (decoded.opcode[cpu_pkg::reg_sel_lsb +: 2])
            2'b00:   store_data = y;
            2'b10:   store_data = x;
            default: store_data = a;
        endcase
    end

    always_comb
    begin
        debug.opcode = decoded.opcode;
        debug.pc     = pc;
        debug.a      = a;
        debug.x      = x;
        debug.y      = y;
        debug.p      = {flag_n, flag_v, 2'b11, 2'b00, flag_z, flag_c}; // B and bit 5 read as 1
    end

endmodule : register_result

`default_nettype wire

// File: design/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top
    ( input  logic              clock,
      input  logic              reset,
      input  logic              enable,
      input  cpu_pkg::byte_t    data_in,
      output cpu_pkg::bus_req_t bus,
      output logic              sync,
      output cpu_pkg::debug_t   debug
      );

    cpu_pkg::decoded_t decoded;
    cpu_pkg::cycle_t   cycle;
    cpu_pkg::ctrl_t    ctrl;
    cpu_pkg::byte_t    data_reg;
    cpu_pkg::addr_t    pc;
    cpu_pkg::byte_t    store_data;
    cpu_pkg::byte_t    a;
    cpu_pkg::byte_t    x;
    cpu_pkg::byte_t    y;
    logic              carry;
    cpu_pkg::byte_t    alu_result;
    logic              alu_carry;
    logic              alu_overflow;
    cpu_pkg::byte_t    count;

    instr_decode u_decode
        ( .clock(clock), .reset(reset), .enable(enable), .data_in(data_in),
          .fetch(cycle.byte1), .decoded(decoded), .opcode() );

    cycle_sequencer u_sequencer
        ( .clock(clock), .reset(reset), .enable(enable), .decoded(decoded),
          .data_in(data_in), .pc(pc), .store_data(store_data), .bus(bus),
          .data_reg(data_reg), .ctrl(ctrl), .cycle(cycle) );

    alu_unit u_alu
        ( .a(a), .x(x), .y(y), .operand(data_reg), .carry_in(carry), .decoded(decoded),
          .result(alu_result), .carry_out(alu_carry), .overflow_out(alu_overflow),
          .count(count) );

    register_result u_result
        ( .clock(clock), .reset(reset), .enable(enable), .ctrl(ctrl), .decoded(decoded),
          .data_in(data_reg), .alu_result(alu_result), .alu_carry(alu_carry),
          .alu_overflow(alu_overflow), .count(count), .a(a), .x(x), .y(y), .carry(carry),
          .store_data(store_data), .pc(pc), .debug(debug) );

    assign sync = cycle.byte1; // Opcode fetch

endmodule : cpu_top

`default_nettype wire

// File: include/cpu_tb_model.svh
`ifndef CPU_TB_MODEL_SVH
`define CPU_TB_MODEL_SVH

// Architectural state, plus the bus write that the last instruction makes
typedef struct packed {
    logic [7:0]  a;
    logic [7:0]  x;
    logic [7:0]  y;
    logic        n;
    logic        v;
    logic        z;
    logic        c;
    logic        we;
    logic [15:0] waddr;
    logic [7:0]  wdata;
} model_t;

// Each entry is {opcode, operand}; implied opcodes ignore the operand byte
localparam int program_length = 46;
localparam logic [15:0] program_table [program_length] = '{
    16'ha950, 16'h6950, 16'hb800, 16'h3800,  // 50+50 overflows, then SEC
    16'he9f0, 16'h1800, 16'h69ff, 16'hc9af,  // Borrow, carry out, equal compare
    16'hc9ff, 16'h090f, 16'h293c, 16'h49ff,  // Compare below, logic ops
    16'ha27f, 16'he800, 16'hca00, 16'ha000,  // X through 7F/80
    16'h8800, 16'hc800, 16'he07f, 16'hc001,  // Y wraps both ways
    16'haa00, 16'ha800, 16'ha900, 16'h8a00,
    16'ha900, 16'h9800, 16'h8510, 16'h8611,  // Stores to 10..12
    16'h8412, 16'ha901, 16'h6510, 16'ha611,  // Reads back what was stored
    16'ha412, 16'ha510, 16'h3800, 16'he511,
    16'hc512, 16'h0513, 16'h2510, 16'h4511,  // 13 still holds the fill byte
    16'ha980, 16'h6980, 16'h8510, 16'ha510,  // 80+80 carry and overflow
    16'hb800, 16'hb800                       // Trailing pair drains the pipeline
};

function automatic logic is_implied(input logic [7:0] op);
    return (op[3:0] == 4'h8) || (op[3:0] == 4'ha);
endfunction

function automatic int instr_cycles(input logic [7:0] op);
    return (op[3:2] == 2'b01) ? 3 : 2; // Low nibble 4..6 is zero page
endfunction

function automatic logic [7:0] fill_byte(input int addr);
    return addr[7:0] ^ addr[15:8] ^ 8'h3c;
endfunction

function automatic logic [7:0] status_byte(input model_t s);
    return {s.n, s.v, 2'b11, 2'b00, s.z, s.c}; // NV11_00ZC
endfunction

function automatic model_t with_nz(input model_t s, input logic [7:0] value);
    model_t r;
    r = s;
    r.n = value[7];
    r.z = (value == 8'h00);
    return r;
endfunction

// Register minus memory, carry set when no borrow
function automatic model_t compared(input model_t s, input logic [7:0] reg_value,
                                    input logic [7:0] m);
    model_t r;
    logic [8:0] diff;
    diff = {1'b0, reg_value} + {1'b0, ~m} + 9'd1;
    r = with_nz(s, diff[7:0]);
    r.c = diff[8];
    return r;
endfunction

function automatic model_t model_step(input logic [7:0] op, input logic [7:0] operand,
                                      input logic [7:0] mem_byte, input model_t s);
    model_t r;
    logic [7:0] m;
    logic [7:0] b;
    logic [8:0] sum;
    r = s;
    r.we = 1'b0;
    r.waddr = '0;
    r.wdata = '0;
    m = (op[3:2] == 2'b01) ? mem_byte : operand;
    b = (op[7:5] == 3'b111) ? ~m : m;        // SBC adds the complement
    sum = {1'b0, s.a} + {1'b0, b} + {8'h00, s.c};
    case (op)
        8'h09, 8'h05: r.a = s.a | m;
        8'h29, 8'h25: r.a = s.a & m;
        8'h49, 8'h45: r.a = s.a ^ m;
        8'h69, 8'h65, 8'he9, 8'he5:
        begin
            r.a = sum[7:0];
            r.c = sum[8];
            r.v = (s.a[7] == b[7]) && (sum[7] != s.a[7]); // Same signs in, other sign out
        end
        8'ha9, 8'ha5: r.a = m;
        8'ha2, 8'ha6: r.x = m;
        8'ha0, 8'ha4: r.y = m;
        8'haa: r.x = s.a;
        8'ha8: r.y = s.a;
        8'h8a: r.a = s.x;
        8'h98: r.a = s.y;
        8'he8: r.x = s.x + 8'd1;
        8'hc8: r.y = s.y + 8'd1;
        8'hca: r.x = s.x - 8'd1;
        8'h88: r.y = s.y - 8'd1;
        default: ;
    endcase
    case (op)
        8'h09, 8'h05, 8'h29, 8'h25, 8'h49, 8'h45, 8'h69, 8'h65, 8'he9, 8'he5,
        8'ha9, 8'ha5, 8'h8a, 8'h98: r = with_nz(r, r.a);
        8'ha2, 8'ha6, 8'haa, 8'he8, 8'hca: r = with_nz(r, r.x);
        8'ha0, 8'ha4, 8'ha8, 8'hc8, 8'h88: r = with_nz(r, r.y);
        8'hc9, 8'hc5: r = compared(r, s.a, m);
        8'he0: r = compared(r, s.x, m);
        8'hc0: r = compared(r, s.y, m);
        8'h18: r.c = 1'b0;
        8'h38: r.c = 1'b1;
        8'hb8: r.v = 1'b0;
        8'h85, 8'h86, 8'h84:
        begin
            r.we = 1'b1;
            r.waddr = {8'h00, operand};
            r.wdata = (op == 8'h85) ? s.a : (op == 8'h86) ? s.x : s.y;
        end
        default: ;
    endcase
    return r;
endfunction

`endif

// File: sim/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

    `include "cpu_tb_model.svh"

    logic              clock = 1'b0;
    logic              reset;
    logic              enable;
    cpu_pkg::byte_t    data_in;
    cpu_pkg::bus_req_t bus;
    logic              sync;
    cpu_pkg::debug_t   debug;

    logic [7:0]  mem [0:65535];                 // Whole address space
    logic [7:0]  ref_mem [0:255];               // Zero page as the model sees it
    logic [15:0] fetch_addr [0:program_length]; // Opcode address per instruction
    integer      seed = 32'h7e1b;
    int          fetch_index = 0;
    int          enabled_cycles = 0;
    int          cycle_count = 0;
    int          cycle_limit = 1000;
    int          error_count = 0;
    model_t      lead;       // State after all but the instruction in flight
    model_t      pending;    // Model result of the instruction in flight
    logic        write_seen;

    cpu_top uut
        ( .clock(clock), .reset(reset), .enable(enable), .data_in(data_in),
          .bus(bus), .sync(sync), .debug(debug) );

    always #5 clock = ~clock;

    assign data_in = mem[bus.address]; // Combinational read

    always @(posedge clock)
    begin
        if (!reset && enable && bus.write_enable)
            mem[bus.address] <= bus.data_out;
    end

    task automatic compare_value(input string name, input logic [15:0] expected,
                                 input logic [15:0] actual);
        if (actual !== expected)
        begin
            error_count++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            $display("Test failures found");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic fail_run(input string reason);
        error_count++;
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1, "Stopped on a failure");
    endtask

    // Debug lags the model by one instruction at every fetch
    task automatic check_state();
        logic [7:0] op;
        if (fetch_index > 0)
        begin
            op = program_table[fetch_index-1][15:8];
            compare_value($sformatf("cycles of instr %0d", fetch_index-1),
                          instr_cycles(op), enabled_cycles);
            compare_value($sformatf("opcode of instr %0d", fetch_index-1), op, debug.opcode);
            if (pending.we && !write_seen)
                fail_run($sformatf("Store %0d made no bus write", fetch_index-1));
        end
        compare_value($sformatf("fetch address %0d", fetch_index), fetch_addr[fetch_index],
                      bus.address);
        compare_value($sformatf("pc %0d", fetch_index), fetch_addr[fetch_index], debug.pc);
        compare_value("write_enable at fetch", 16'h0, bus.write_enable);
        compare_value($sformatf("A at fetch %0d", fetch_index), lead.a, debug.a);
        compare_value($sformatf("X at fetch %0d", fetch_index), lead.x, debug.x);
        compare_value($sformatf("Y at fetch %0d", fetch_index), lead.y, debug.y);
        compare_value($sformatf("P at fetch %0d", fetch_index), status_byte(lead), debug.p);
    endtask

    task automatic advance_model();
        logic [7:0] op;
        logic [7:0] opd;
        if (fetch_index > 0)
        begin
            op = program_table[fetch_index-1][15:8];
            opd = program_table[fetch_index-1][7:0];
            lead = model_step(op, opd, ref_mem[opd], lead);
            if (lead.we)
                ref_mem[lead.waddr[7:0]] = lead.wdata; // Stored byte feeds later reads
        end
        op = program_table[fetch_index][15:8];
        opd = program_table[fetch_index][7:0];
        pending = model_step(op, opd, ref_mem[opd], lead);
        write_seen = 1'b0;
        enabled_cycles = 1;
        fetch_index++;
    endtask

    task automatic check_write();
        if (!pending.we || write_seen)
            fail_run("Bus write from an instruction that stores nothing");
        compare_value("write address", pending.waddr, bus.address);
        compare_value("write data", pending.wdata, bus.data_out);
        write_seen = 1'b1;
    endtask

    // Outputs are settled half a period after the edge
    always @(negedge clock)
    begin
        if (reset)
            compare_value("write_enable in reset", 16'h0, bus.write_enable);
        else if (enable && sync && fetch_index == program_length)
        begin
            check_state();
            if (error_count == 0)
                $display("All tests passed!");
            else
                $display("Test failures found");
            $finish;
        end
        else if (enable)
        begin
            if (bus.write_enable)
                check_write();
            if (sync)
            begin
                check_state();
                advance_model();
            end
            else
                enabled_cycles++;
        end
    end

    always @(posedge clock)
    begin
        if (reset)
            enable <= 1'b1;
        else
            enable <= ($random(seed) & 3) != 0; // Frozen on about one cycle in four
    end

    always @(posedge clock)
    begin
        if (!reset)
        begin
            cycle_count++;
            if (cycle_count > cycle_limit)
                fail_run("Timeout: the program did not finish in time");
        end
    end

    initial
    begin
        int addr;
        int total;
        reset = 1'b1;
        enable = 1'b0;
        lead = '0;   // Registers and flags clear at reset
        pending = '0;
        write_seen = 1'b0;
        for (int i = 0; i < 65536; i++)
            mem[i] = fill_byte(i);
        for (int i = 0; i < 256; i++)
            ref_mem[i] = fill_byte(i);
        addr = int'(cpu_pkg::reset_pc);
        total = 0;
        for (int k = 0; k < program_length; k++)
        begin
            fetch_addr[k] = addr[15:0];
            mem[addr] = program_table[k][15:8];
            addr++;
            if (!is_implied(program_table[k][15:8]))
            begin
                mem[addr] = program_table[k][7:0];
                addr++;
            end
            total += instr_cycles(program_table[k][15:8]);
        end
        fetch_addr[program_length] = addr[15:0];
        cycle_limit = 4 * total;
        repeat (5) @(posedge clock);
        reset <= 1'b0;
    end

endmodule : cpu_tb

`default_nettype wire

// File: sim.f
+incdir+include
design/cpu_pkg.sv
design/instr_decode.sv
design/cycle_sequencer.sv
design/alu_unit.sv
design/register_result.sv
design/cpu_top.sv
sim/cpu_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= cpu_tb
FILELIST  ?= sim.f
PASS_TEXT := All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf obj_dir
